//--- testbench/icache_stimulus.txt
# mark <line number hex>, a line whose halfwords all read as 32-bit opcodes
# fetch <test id> <halfword address hex> <expected fetch word hex> <expected refills>
mark 2
# cold miss on line 1
fetch 1 8 78DDE6C4 1
# hits in the same line
fetch 2 9 607578DD 0
fetch 2 B DA261715 0
fetch 2 E 538453D7 0
# 32-bit opcode at offset 7, next line missing then present
fetch 3 17 B44CCC63 2
fetch 3 17 B44CCC63 0
# compressed opcode at offset 7
fetch 4 F 00005384 0
# set 0 with tags A B A C B
fetch 5 2 9E3779B1 1
fetch 5 24 1FE68E72 1
fetch 5 5 6D133C6E 0
fetch 5 40 C6EF3620 1
fetch 5 21 14C1E377 1
# second way of set 1 under random ack delays
fetch 6 2B 7536FA8C 1
fetch 6 2E 36FBEEE7 0
fetch 6 28 5C5581D4 0
fetch 6 8 78DDE6C4 0

//--- compile.f
hdl/icache_pkg.sv
hdl/refill_beat_counter.sv
hdl/icache_tag_data_2way.sv
hdl/fetch_align.sv
hdl/icache_ctrl_fsm.sv
hdl/icache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - files:
      - hdl/icache_pkg.sv
      - hdl/refill_beat_counter.sv
      - hdl/icache_tag_data_2way.sv
      - hdl/fetch_align.sv
      - hdl/icache_ctrl_fsm.sv
      - hdl/icache_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_icache.sv

//--- testbench/tb_icache.sv
`timescale 1ns/100ps

module tb_icache;

    localparam int SETS          = 4;
    localparam int DRIVE_DELAY   = 2;
    localparam int STALL_TIMEOUT = 200;
    localparam int RESET_TIMEOUT = 20;
    localparam int MEM_IDLE      = 0;
    localparam int MEM_WAIT      = 1;
    localparam int MEM_ACK       = 2;
    localparam logic [31:0] LFSR_SEED = 32'd90256;

    logic                    clk;
    logic                    proc_reset;
    logic                    proc_read;
    icache_pkg::fetch_addr_t proc_addr;
    logic [31:0]             proc_rdata;
    logic                    proc_stall;
    logic                    mem_req;
    logic [29:0]             mem_addr;
    logic                    mem_ack;
    logic [31:0]             mem_rdata;

    // memory model and bookkeeping
    logic [31:0] lfsr_q;
    logic [27:0] marked_lines[$];
    int          mem_phase;
    int          delay_left;
    logic        ack_next;
    logic [31:0] rdata_next;
    logic        req_seen_q;
    int          req_rises;
    int          error_count;
    int          cur_test;
    int          test_fetches;
    int          test_err_start;
    int          test_count;
    int          total_fetches;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (5)
    ) u_clock_gen (
        .clk_o   (clk),
        .reset_o (proc_reset)
    );

    icache_top #(
        .SETS (SETS)
    ) u_dut (
        .clk          (clk),
        .proc_reset_i (proc_reset),
        .proc_read_i  (proc_read),
        .proc_addr_i  (proc_addr),
        .proc_rdata_o (proc_rdata),
        .proc_stall_o (proc_stall),
        .mem_req_o    (mem_req),
        .mem_addr_o   (mem_addr),
        .mem_ack_i    (mem_ack),
        .mem_rdata_i  (mem_rdata)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output int d);
        d = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            d = (d << 1) | int'(lfsr_q[0]);
        end
    endtask

    // golden-ratio hash of the word address
    function automatic logic [31:0] memory_word(input logic [29:0] w);
        logic [31:0] v;
        v = {2'b00, w} * 32'h9E3779B1;
        foreach (marked_lines[i]) begin
            if (marked_lines[i] == w[29:2]) begin
                v = v | 32'h0003_0003;
            end
        end
        return v;
    endfunction

    function automatic icache_pkg::fetch_addr_t make_addr(input logic [31:0] ha);
        icache_pkg::fetch_addr_t a;
        a.tag    = ha[30:5];
        a.index  = {1'b0, ha[4:3]};
        a.offset = ha[2:0];
        return a;
    endfunction

    task automatic check(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: test %0d %s got %h expected %h",
                     $time, cur_test, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic drive_edge();
        @(posedge clk);
        #DRIVE_DELAY;
        mem_ack   = ack_next;
        mem_rdata = rdata_next;
    endtask

    // one call per cycle, at the falling edge where outputs are settled
    task automatic observe_cycle();
        int delay;
        @(negedge clk);
        if (mem_req && !req_seen_q) begin
            req_rises++;
        end
        req_seen_q = mem_req;
        case (mem_phase)
            MEM_IDLE: begin
                if (mem_req) begin
                    draw_delay(delay);
                    delay_left = delay;
                    mem_phase  = MEM_WAIT;
                end
            end
            MEM_ACK: begin
                if (!mem_req) begin
                    ack_next  = 1'b0;
                    mem_phase = MEM_IDLE;
                end
            end
            default: begin
                delay_left--;
            end
        endcase
        if (mem_phase == MEM_WAIT && delay_left <= 0) begin
            ack_next   = 1'b1;
            rdata_next = memory_word(mem_addr);
            mem_phase  = MEM_ACK;
        end
    endtask

    task automatic run_fetch(input logic [31:0] ha, input logic [31:0] exp_word,
                             input int exp_refills);
        int waited;
        int rises;
        drive_edge();
        proc_read = 1'b1;
        proc_addr = make_addr(ha);
        rises     = req_rises;
        observe_cycle();
        waited = 0;
        while (proc_stall && waited < STALL_TIMEOUT) begin
            drive_edge();
            observe_cycle();
            waited++;
        end
        if (proc_stall) begin
            abort_run($sformatf("timeout: stall still high after %0d cycles, fetch at %h",
                                STALL_TIMEOUT, ha));
        end else begin
            check($sformatf("fetch word at %h", ha), proc_rdata, exp_word);
            rises = req_rises - rises;
            check($sformatf("refills for %h", ha), rises / 4, exp_refills);
            check($sformatf("partial line beats for %h", ha), rises % 4, 0);
            test_fetches++;
            total_fetches++;
            // one idle cycle between fetches
            drive_edge();
            proc_read = 1'b0;
            observe_cycle();
        end
    endtask

    task automatic report_test();
        $display("test %0d: %0d fetches, %0d errors, %s", cur_test, test_fetches,
                 error_count - test_err_start,
                 (error_count == test_err_start) ? "pass" : "fail");
        test_count++;
    endtask

    initial begin
        int          fd;
        int          code;
        int          ch;
        int          waited;
        int          id;
        int          exp_refills;
        logic [127:0] kind;
        logic [27:0] mark_line;
        logic [31:0] haddr;
        logic [31:0] exp_word;
        logic        done;

        proc_read      = 1'b0;
        proc_addr      = '0;
        mem_ack        = 1'b0;
        mem_rdata      = '0;
        lfsr_q         = LFSR_SEED;
        mem_phase      = MEM_IDLE;
        delay_left     = 0;
        ack_next       = 1'b0;
        rdata_next     = '0;
        req_seen_q     = 1'b0;
        req_rises      = 0;
        error_count    = 0;
        cur_test       = -1;
        test_fetches   = 0;
        test_err_start = 0;
        test_count     = 0;
        total_fetches  = 0;

        waited = 0;
        while (proc_reset !== 1'b0 && waited < RESET_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        fd = $fopen("testbench/icache_stimulus.txt", "r");
        if (proc_reset !== 1'b0) begin
            abort_run("reset was never released");
        end else if (fd == 0) begin
            abort_run("could not open testbench/icache_stimulus.txt");
        end else begin
            check("mem_req after reset", 32'(mem_req), 0);
            check("stall after reset", 32'(proc_stall), 0);
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", kind);
                if (code != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (kind == "mark") begin
                    code = $fscanf(fd, "%h", mark_line);
                    marked_lines.push_back(mark_line);
                end else if (kind == "fetch" &&
                             $fscanf(fd, "%d %h %h %d", id, haddr, exp_word, exp_refills) == 4) begin
                    if (id != cur_test) begin
                        if (test_fetches > 0) begin
                            report_test();
                        end
                        cur_test       = id;
                        test_fetches   = 0;
                        test_err_start = error_count;
                    end
                    run_fetch(haddr, exp_word, exp_refills);
                end else begin
                    $display("stimulus file holds a line that cannot be read");
                    error_count++;
                    done = 1'b1;
                end
            end
            $fclose(fd);
            if (test_fetches > 0) begin
                report_test();
            end
            if (total_fetches == 0) begin
                $display("stimulus file held no fetches");
                error_count++;
            end
            $display("summary: %0d tests, %0d fetches, %0d errors",
                     test_count, total_fetches, error_count);
            if (error_count == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // released shortly after an edge, like every other driven input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 reset_o = 1'b0;
    end

endmodule

//--- hdl/icache_top.sv
`timescale 1ns/100ps

module icache_top #(
    parameter int SETS = 4
) (
    input  logic                                 clk,
    input  logic                                 proc_reset_i,
    // processor side
    input  logic                                 proc_read_i,
    input  icache_pkg::fetch_addr_t              proc_addr_i,
    output logic [icache_pkg::WORD_W-1:0]        proc_rdata_o,
    output logic                                 proc_stall_o,
    // memory side, four-phase req/ack
    output logic                                 mem_req_o,
    output logic [icache_pkg::WORD_ADDR_W-1:0]   mem_addr_o,
    input  logic                                 mem_ack_i,
    input  logic [icache_pkg::WORD_W-1:0]        mem_rdata_i
);

    icache_pkg::fetch_addr_t         lookup_addr;
    icache_pkg::refill_req_t         fill;
    icache_pkg::line_t               line;
    logic [icache_pkg::BEAT_W-1:0]   beat_idx;
    logic                            next_line;
    logic                            hit;
    logic                            span_needed;
    logic                            beat_last;
    logic                            beat_start;
    logic                            beat_advance;
    logic                            fill_en;

    icache_ctrl_fsm #(
        .SETS (SETS)
    ) u_ctrl (
        .clk            (clk),
        .proc_reset_i   (proc_reset_i),
        .proc_read_i    (proc_read_i),
        .proc_addr_i    (proc_addr_i),
        .hit_i          (hit),
        .span_needed_i  (span_needed),
        .beat_last_i    (beat_last),
        .beat_idx_i     (beat_idx),
        .mem_ack_i      (mem_ack_i),
        .lookup_addr_o  (lookup_addr),
        .next_line_o    (next_line),
        .fill_en_o      (fill_en),
        .fill_o         (fill),
        .beat_start_o   (beat_start),
        .beat_advance_o (beat_advance),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .proc_stall_o   (proc_stall_o)
    );

    refill_beat_counter u_beat_cnt (
        .clk            (clk),
        .proc_reset_i   (proc_reset_i),
        .beat_start_i   (beat_start),
        .beat_advance_i (beat_advance),
        .beat_idx_o     (beat_idx),
        .beat_last_o    (beat_last)
    );

    icache_tag_data_2way #(
        .SETS (SETS)
    ) u_store (
        .clk           (clk),
        .proc_reset_i  (proc_reset_i),
        .lookup_addr_i (lookup_addr),
        .fill_en_i     (fill_en),
        .fill_i        (fill),
        .mem_rdata_i   (mem_rdata_i),
        .hit_o         (hit),
        .line_o        (line)
    );

    fetch_align u_align (
        .clk           (clk),
        .proc_reset_i  (proc_reset_i),
        .line_i        (line),
        .offset_i      (proc_addr_i.offset),
        .next_line_i   (next_line),
        .rdata_o       (proc_rdata_o),
        .span_needed_o (span_needed)
    );

endmodule

//--- hdl/icache_ctrl_fsm.sv
`timescale 1ns/100ps

module icache_ctrl_fsm #(
    parameter int SETS = 4
) (
    input  logic                                 clk,
    input  logic                                 proc_reset_i,
    input  logic                                 proc_read_i,
    input  icache_pkg::fetch_addr_t              proc_addr_i,
    input  logic                                 hit_i,
    input  logic                                 span_needed_i,
    input  logic                                 beat_last_i,
    input  logic [icache_pkg::BEAT_W-1:0]        beat_idx_i,
    input  logic                                 mem_ack_i,
    output icache_pkg::fetch_addr_t              lookup_addr_o,
    output logic                                 next_line_o,
    output logic                                 fill_en_o,
    output icache_pkg::refill_req_t              fill_o,
    output logic                                 beat_start_o,
    output logic                                 beat_advance_o,
    output logic                                 mem_req_o,
    output logic [icache_pkg::WORD_ADDR_W-1:0]   mem_addr_o,
    output logic                                 proc_stall_o
);

    localparam int IDX_W  = $clog2(SETS);
    localparam int LINE_N = icache_pkg::TAG_W + IDX_W;
    localparam int WA_W   = icache_pkg::WORD_ADDR_W;

    icache_pkg::cache_state_e  state_q;
    icache_pkg::cache_state_e  state_d;
    icache_pkg::fetch_addr_t   lookup;
    logic                      next_line_q;
    logic                      next_line_d;
    logic [LINE_N-1:0]         line_num;
    logic [LINE_N-1:0]         next_num;
    logic [LINE_N+icache_pkg::BEAT_W-1:0] word_full;

    // line number of the fetch and of the line after it
    assign line_num = {proc_addr_i.tag, proc_addr_i.index[IDX_W-1:0]};
    assign next_num = line_num + 1'b1;

    always_comb begin
        lookup = proc_addr_i;
        if (next_line_q) begin
            lookup.tag              = next_num[LINE_N-1:IDX_W];
            lookup.index[IDX_W-1:0] = next_num[IDX_W-1:0];
            lookup.offset           = '0;
        end
    end

    assign lookup_addr_o = lookup;
    assign next_line_o   = next_line_q;

    // refill word address of the line being looked up
    assign word_full   = {lookup.tag, lookup.index[IDX_W-1:0], beat_idx_i};
    assign fill_o.addr = WA_W'(word_full);
    assign fill_o.beat = beat_idx_i;
    assign mem_addr_o  = fill_o.addr;

    // req is high only while waiting for ack
    assign mem_req_o      = (state_q == icache_pkg::ST_REFILL_ACK);
    assign beat_advance_o = fill_en_o;

    always_comb begin
        state_d      = state_q;
        next_line_d  = next_line_q;
        beat_start_o = 1'b0;
        fill_en_o    = 1'b0;
        proc_stall_o = 1'b0;
        case (state_q)
            icache_pkg::ST_IDLE: begin
                if (proc_read_i && !hit_i) begin
                    proc_stall_o = 1'b1;
                    beat_start_o = 1'b1;
                    state_d      = icache_pkg::ST_REFILL_REQ;
                end else if (proc_read_i && span_needed_i) begin
                    // upper half lives in the next line
                    proc_stall_o = 1'b1;
                    next_line_d  = 1'b1;
                    state_d      = icache_pkg::ST_NEXTLINE;
                end
            end
            icache_pkg::ST_NEXTLINE: begin
                if (hit_i) begin
                    next_line_d = 1'b0;
                    state_d     = icache_pkg::ST_IDLE;
                end else begin
                    proc_stall_o = 1'b1;
                    beat_start_o = 1'b1;
                    state_d      = icache_pkg::ST_REFILL_REQ;
                end
            end
            icache_pkg::ST_REFILL_REQ: begin
                // previous ack must be gone before req rises again
                proc_stall_o = 1'b1;
                if (!mem_ack_i) begin
                    state_d = icache_pkg::ST_REFILL_ACK;
                end
            end
            icache_pkg::ST_REFILL_ACK: begin
                proc_stall_o = 1'b1;
                if (mem_ack_i) begin
                    fill_en_o = 1'b1;
                    state_d   = beat_last_i ? icache_pkg::ST_REFILL_DONE
                                            : icache_pkg::ST_REFILL_REQ;
                end
            end
            icache_pkg::ST_REFILL_DONE: begin
                proc_stall_o = 1'b1;
                state_d      = next_line_q ? icache_pkg::ST_NEXTLINE : icache_pkg::ST_IDLE;
            end
            default: begin
                state_d = icache_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            state_q     <= icache_pkg::ST_IDLE;
            next_line_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            next_line_q <= next_line_d;
        end
    end

    // req and word address hold until memory answers
    assert property (@(posedge clk) disable iff (proc_reset_i)
        (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_addr_o)));

    // a beat request starts only once memory has dropped ack
    assert property (@(posedge clk) disable iff (proc_reset_i)
        $rose(mem_req_o) |-> !mem_ack_i);

endmodule

//--- hdl/fetch_align.sv
`timescale 1ns/100ps

module fetch_align (
    input  logic                               clk,
    input  logic                               proc_reset_i,
    input  icache_pkg::line_t                  line_i,
    input  logic [icache_pkg::OFFSET_W-1:0]    offset_i,
    input  logic                               next_line_i,
    output logic [icache_pkg::WORD_W-1:0]      rdata_o,
    output logic                               span_needed_o
);

    logic [icache_pkg::HALFS_PER_LINE-1:0][icache_pkg::HALF_W-1:0] hw;
    logic [icache_pkg::HALF_W-1:0] lo_half;
    logic [icache_pkg::HALF_W-1:0] last_hw_q;
    logic                          last_slot;
    logic                          compressed;

    // halfword 0 is the lowest address of the line
    assign hw         = line_i;
    assign lo_half    = hw[offset_i];
    assign last_slot  = (offset_i == icache_pkg::LAST_HALF);
    assign compressed = (lo_half[1:0] != 2'b11);

    assign span_needed_o = !next_line_i && last_slot && !compressed;

    // hold the last halfword of the fetch line while the next line is looked up
    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            last_hw_q <= '0;
        end else if (!next_line_i) begin
            last_hw_q <= hw[icache_pkg::HALFS_PER_LINE-1];
        end
    end

    always_comb begin
        if (next_line_i) begin
            rdata_o = {hw[0], last_hw_q};
        end else if (last_slot) begin
            // nothing beyond the line without the next-line pass
            rdata_o = {{icache_pkg::HALF_W{1'b0}}, lo_half};
        end else begin
            rdata_o = {hw[offset_i + 1'b1], lo_half};
        end
    end

endmodule

//--- hdl/icache_tag_data_2way.sv
`timescale 1ns/100ps

module icache_tag_data_2way #(
    parameter int SETS = 4
) (
    input  logic                             clk,
    input  logic                             proc_reset_i,
    input  icache_pkg::fetch_addr_t          lookup_addr_i,
    input  logic                             fill_en_i,
    input  icache_pkg::refill_req_t          fill_i,
    input  logic [icache_pkg::WORD_W-1:0]    mem_rdata_i,
    output logic                             hit_o,
    output icache_pkg::line_t                line_o
);

    localparam int IDX_W = $clog2(SETS);

    icache_pkg::tag_entry_t tag_q  [2][SETS];
    icache_pkg::line_t      data_q [2][SETS];
    // per set, the way to replace next
    logic [SETS-1:0]        lru_q;
    logic                   victim_q;
    logic [IDX_W-1:0]       idx;
    logic [1:0]             way_hit;
    logic                   hit_way;
    logic                   fill_way;
    logic                   fill_first;
    logic                   fill_last;

    assign idx = lookup_addr_i.index[IDX_W-1:0];

    // tag compare in both ways
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = tag_q[w][idx].valid && (tag_q[w][idx].tag == lookup_addr_i.tag);
        end
    end

    assign hit_o   = |way_hit;
    assign hit_way = way_hit[1];
    assign line_o  = hit_way ? data_q[1][idx] : data_q[0][idx];

    assign fill_first = (fill_i.beat == '0);
    assign fill_last  = (fill_i.beat == icache_pkg::LAST_BEAT);
    // victim taken from LRU on the first beat, then held
    assign fill_way   = fill_first ? lru_q[idx] : victim_q;

    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    tag_q[w][s].valid <= 1'b0;
                end
            end
            lru_q    <= '0;
            victim_q <= 1'b0;
        end else begin
            if (fill_en_i && fill_first) begin
                victim_q <= lru_q[idx];
            end
            if (fill_en_i && fill_last) begin
                tag_q[fill_way][idx] <= '{valid: 1'b1, tag: lookup_addr_i.tag};
                lru_q[idx]           <= ~fill_way;
            end else if (hit_o) begin
                lru_q[idx] <= ~hit_way;
            end
        end
    end

    // one word per beat
    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            data_q[fill_way][idx][fill_i.beat] <= mem_rdata_i;
        end
    end

    // fills go only to the victim, so a line is never held twice
    assert property (@(posedge clk) disable iff (proc_reset_i)
        !(way_hit[0] && way_hit[1]));

endmodule

//--- hdl/refill_beat_counter.sv
`timescale 1ns/100ps

module refill_beat_counter (
    input  logic                            clk,
    input  logic                            proc_reset_i,
    input  logic                            beat_start_i,
    input  logic                            beat_advance_i,
    output logic [icache_pkg::BEAT_W-1:0]   beat_idx_o,
    output logic                            beat_last_o
);

    logic [icache_pkg::BEAT_W-1:0] beat_idx_q;

    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            beat_idx_q <= '0;
        end else if (beat_start_i) begin
            beat_idx_q <= '0;
        end else if (beat_advance_i) begin
            // wraps to zero after the last beat
            beat_idx_q <= beat_idx_q + 1'b1;
        end
    end

    assign beat_idx_o  = beat_idx_q;
    assign beat_last_o = (beat_idx_q == icache_pkg::LAST_BEAT);

    // a line takes exactly four beats per start
    assert property (@(posedge clk) disable iff (proc_reset_i)
        (beat_advance_i && beat_last_o) |=> (!beat_advance_i until beat_start_i));

endmodule

//--- hdl/icache_pkg.sv
package icache_pkg;

    // fixed field widths of the halfword fetch address
    localparam int TAG_W       = 26;
    localparam int OFFSET_W    = 3;
    // index field sized for the largest set count (8)
    localparam int INDEX_W_MAX = 3;

    // line and word geometry
    localparam int LINE_W         = 128;
    localparam int WORD_W         = 32;
    localparam int HALF_W         = 16;
    localparam int BEATS_PER_LINE = 4;
    localparam int HALFS_PER_LINE = LINE_W / HALF_W;
    localparam int BEAT_W         = $clog2(BEATS_PER_LINE);
    localparam int WORD_ADDR_W    = 30;

    localparam logic [BEAT_W-1:0]   LAST_BEAT = BEAT_W'(BEATS_PER_LINE - 1);
    localparam logic [OFFSET_W-1:0] LAST_HALF = OFFSET_W'(HALFS_PER_LINE - 1);

    // processor fetch address, modules with fewer sets use the low index bits
    typedef struct packed {
        logic [TAG_W-1:0]       tag;
        logic [INDEX_W_MAX-1:0] index;
        logic [OFFSET_W-1:0]    offset;
    } fetch_addr_t;

    // word 0 sits in the low 32 bits
    typedef logic [BEATS_PER_LINE-1:0][WORD_W-1:0] line_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    // one refill beat: memory word address and the word slot in the line
    typedef struct packed {
        logic [WORD_ADDR_W-1:0] addr;
        logic [BEAT_W-1:0]      beat;
    } refill_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_NEXTLINE,
        ST_REFILL_REQ,
        ST_REFILL_ACK,
        ST_REFILL_DONE
    } cache_state_e;

endpackage
